//--- flist.f
design/l2GeomPkg.sv
design/l2CtrlPkg.sv
design/cacheIfs.sv
design/sramPort.sv
design/ddrPort.sv
design/cacheCtrl.sv
design/l2Cache.sv
tests/l2Cache_props.sv
tests/l2CacheTb.sv

//--- Makefile
# Verilator build and run for the L2 cache testbench

VERILATOR ?= verilator
TOP       ?= l2CacheTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/l2CacheTb.sv
`timescale 1ns/1ps

module l2CacheTb import l2GeomPkg::*, l2CtrlPkg::*; ();

    localparam int IndexBits = 4;
    localparam int Lines     = 1 << IndexBits;
    localparam int Seed      = 46;
    localparam int MaxDelay  = 4;
    localparam int WaitLimit = 400;  // in cycles, enough for the clear

    typedef logic [767:0] wideT;

    logic                 clk;
    logic                 rst;
    addrT                 hostAddr;
    lineT                 hostDin;
    logic                 hostStb;
    logic                 hostWe;
    logic                 hostAck;
    lineT                 hostDout;
    logic                 sramStb;
    logic                 sramWe;
    logic [IndexBits-1:0] sramIndex;
    sramLineT             sramDin;
    logic                 sramAck;
    sramLineT             sramDout;
    logic                 ddrStb;
    logic                 ddrWe;
    addrT                 ddrAddr;
    lineT                 ddrDin;
    logic                 ddrAck;
    lineT                 ddrDout;

    sramLineT sramMem [Lines];
    lineT     ddrMem [addrT];
    lineT     hostWrites [addrT];  // last host line per address
    int       clrHits [Lines];
    int       clrCount;
    int       ackCount;
    int       ddrReads;
    int       ddrWrites;
    addrT     lastRdAddr;
    addrT     lastWrAddr;
    lineT     lastWrData;

    l2Cache #(.IndexBits(IndexBits)) i_dut (
        .clk(clk), .rst(rst),
        .hostAddr(hostAddr), .hostDin(hostDin), .hostStb(hostStb), .hostWe(hostWe),
        .hostAck(hostAck), .hostDout(hostDout),
        .sramStb(sramStb), .sramWe(sramWe), .sramIndex(sramIndex), .sramDin(sramDin),
        .sramAck(sramAck), .sramDout(sramDout),
        .ddrStb(ddrStb), .ddrWe(ddrWe), .ddrAddr(ddrAddr), .ddrDin(ddrDin),
        .ddrAck(ddrAck), .ddrDout(ddrDout)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fill for never written lines, distinct for every address
    function automatic lineT ddrPattern(addrT a);
        lineT l;
        for (int w = 0; w < LineWords; w++) begin
            l[w*WordWidth +: WordWidth] = (a * 32'h2c1b_3c6d) ^ (32'h9e37_79b9 * (w + 1));
        end
        return l;
    endfunction

    function automatic lineT refLine(addrT a);
        if (hostWrites.exists(a)) begin
            return hostWrites[a];
        end
        return ddrPattern(a);
    endfunction

    function automatic lineT storedData(sramLineT s);
        lineT l;
        for (int w = 0; w < LineWords; w++) begin
            l[w*WordWidth +: WordWidth] = s[w*SramWordWidth +: WordWidth];
        end
        return l;
    endfunction

    function automatic lineT randLine();
        lineT l;
        for (int w = 0; w < LineWords; w++) begin
            l[w*WordWidth +: WordWidth] = $urandom;
        end
        return l;
    endfunction

    function automatic addrT lineAddr(int tag, int idx);
        return (addrT'(tag) << TagLsb) | (addrT'(idx) << OffsetBits);
    endfunction

    task automatic checkEq(input string name, input wideT got, input wideT exp);
        if (got !== exp) begin
            $display("ERR %0t %s got=%0h exp=%0h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("timeout while waiting for %s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    // host holds the request until ack and drops strobe a cycle later
    task automatic hostOp(input addrT a, input logic we, input lineT d);
        int n;
        @(negedge clk);
        hostAddr = a;
        hostWe   = we;
        hostDin  = d;
        hostStb  = 1'b1;
        n = 0;
        while (hostAck !== 1'b1) begin
            if (n == WaitLimit) begin
                timeoutFail("hostAck");
            end
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        hostStb = 1'b0;
    endtask

    initial begin : sramModel
        logic                 we;
        logic [IndexBits-1:0] idx;
        sramLineT             din;
        sramAck  = 1'b0;
        sramDout = '0;
        forever begin
            @(negedge clk);
            if (sramStb === 1'b1) begin
                we  = sramWe;
                idx = sramIndex;
                din = sramDin;
                repeat ($urandom_range(MaxDelay, 1)) @(negedge clk);
                if (we) begin
                    sramMem[idx] = din;
                    if (din[WordWidth + LabelValid] == 1'b0) begin  // clear write
                        clrCount++;
                        clrHits[idx]++;
                    end
                end else begin
                    sramDout = sramMem[idx];
                end
                sramAck = 1'b1;
                @(negedge clk);
                sramAck = 1'b0;
            end
        end
    end

    initial begin : ddrModel
        logic we;
        addrT adr;
        lineT din;
        ddrAck  = 1'b0;
        ddrDout = '0;
        forever begin
            @(negedge clk);
            if (ddrStb === 1'b1) begin
                we  = ddrWe;
                adr = ddrAddr;
                din = ddrDin;
                repeat ($urandom_range(MaxDelay, 1)) @(negedge clk);
                if (we) begin
                    ddrMem[adr] = din;
                    ddrWrites++;
                    lastWrAddr = adr;
                    lastWrData = din;
                end else begin
                    ddrDout = ddrMem.exists(adr) ? ddrMem[adr] : ddrPattern(adr);
                    ddrReads++;
                    lastRdAddr = adr;
                end
                ddrAck = 1'b1;
                @(negedge clk);
                ddrAck = 1'b0;
            end
        end
    end

    // every read ack against the reference
    initial begin : compare
        forever begin
            @(negedge clk);
            if (hostAck === 1'b1) begin
                if (ackCount == 0) begin
                    checkEq("clearWrites", wideT'(clrCount), wideT'(Lines));
                end
                if (hostWe) begin
                    hostWrites[hostAddr] = hostDin;
                end else begin
                    checkEq("hostDout", wideT'(hostDout), wideT'(refLine(hostAddr)));
                end
                ackCount++;
            end
        end
    end

    initial begin : stimulus
        addrT a;
        addrT b;
        lineT wr;
        int   rd0;
        int   wr0;
        int   tag;
        int   idx;
        logic we;
        void'($urandom(Seed));
        rst        = 1'b1;
        hostAddr   = '0;
        hostDin    = '0;
        hostStb    = 1'b0;
        hostWe     = 1'b0;
        clrCount   = 0;
        ackCount   = 0;
        ddrReads   = 0;
        ddrWrites  = 0;
        lastRdAddr = '0;
        lastWrAddr = '0;
        lastWrData = '0;
        foreach (clrHits[i]) clrHits[i] = 0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        a = lineAddr(1, 3);
        b = lineAddr(2, 3);

        // read miss on a clean line issued while the clear runs
        rd0 = ddrReads;
        wr0 = ddrWrites;
        hostOp(a, 1'b0, '0);
        foreach (clrHits[i]) checkEq($sformatf("clrHits[%0d]", i), wideT'(clrHits[i]), 1);
        checkEq("ddrReads", wideT'(ddrReads), wideT'(rd0 + 1));
        checkEq("ddrWrites", wideT'(ddrWrites), wideT'(wr0));
        checkEq("ddrRdAddr", wideT'(lastRdAddr), wideT'(a));
        checkEq("sramLabel", wideT'(sramMem[3][WordWidth +: LabelBits]), {tagT'(1), 2'b01});
        checkEq("sramData", wideT'(storedData(sramMem[3])), wideT'(refLine(a)));

        // read hit
        rd0 = ddrReads;
        hostOp(a, 1'b0, '0);
        checkEq("ddrTraffic", wideT'(ddrReads + ddrWrites), wideT'(rd0 + wr0));

        // write then read back
        wr = randLine();
        hostOp(a, 1'b1, wr);
        hostOp(a, 1'b0, '0);
        checkEq("ddrTraffic", wideT'(ddrReads + ddrWrites), wideT'(rd0 + wr0));

        // other tag at the same index pushes out the dirty line
        hostOp(b, 1'b0, '0);
        checkEq("ddrWrites", wideT'(ddrWrites), wideT'(wr0 + 1));
        checkEq("ddrWrAddr", wideT'(lastWrAddr), wideT'(a));
        checkEq("ddrWrData", wideT'(lastWrData), wideT'(wr));
        checkEq("ddrReads", wideT'(ddrReads), wideT'(rd0 + 1));
        checkEq("ddrRdAddr", wideT'(lastRdAddr), wideT'(b));
        hostOp(a, 1'b0, '0);  // comes back from DDR with the written data

        for (int k = 0; k < 150; k++) begin
            tag = 5 + $urandom_range(2, 0);
            idx = $urandom_range(3, 0);
            we  = ($urandom % 2) == 1;
            hostOp(lineAddr(tag, idx), we, we ? randLine() : '0);
        end

        checkEq("clearWrites", wideT'(clrCount), wideT'(Lines));
        $display("sim passed");
        $finish;
    end

endmodule

//--- tests/l2Cache_props.sv
`timescale 1ns/1ps

module l2CacheProps import l2CtrlPkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      hostStb,
    input logic      hostAck,
    input logic      sramReq,
    input logic      ddrReq,
    input ctrlStateT state
);

    // port strobes trail these requests by one cycle
    assert property (@(posedge clk) disable iff (rst) !(sramReq && ddrReq))
        else $error("SRAM and DDR requests overlap");

    assert property (@(posedge clk) disable iff (rst) hostAck |=> !hostAck)
        else $error("hostAck held longer than one cycle");

    assert property (@(posedge clk) disable iff (rst) hostAck |-> hostStb)
        else $error("hostAck without hostStb");

    // only the first clear write may be pending right after reset
    assert property (@(posedge clk) rst |=> state == Clear && !ddrReq && !hostAck)
        else $error("unexpected strobe in the cycle after reset");

endmodule

bind cacheCtrl l2CacheProps i_props (
    .clk     (clk),
    .rst     (rst),
    .hostStb (hostStb),
    .hostAck (hostAck),
    .sramReq (sram.req),
    .ddrReq  (ddr.req),
    .state   (state)
);

//--- design/l2Cache.sv
`timescale 1ns/1ps

module l2Cache import l2GeomPkg::*; #(
    parameter int IndexBits = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    // host bus
    input  addrT                 hostAddr,
    input  lineT                 hostDin,
    input  logic                 hostStb,
    input  logic                 hostWe,
    output logic                 hostAck,
    output lineT                 hostDout,
    // line SRAM
    output logic                 sramStb,
    output logic                 sramWe,
    output logic [IndexBits-1:0] sramIndex,
    output sramLineT             sramDin,
    input  logic                 sramAck,
    input  sramLineT             sramDout,
    // DDR
    output logic                 ddrStb,
    output logic                 ddrWe,
    output addrT                 ddrAddr,
    output lineT                 ddrDin,
    input  logic                 ddrAck,
    input  lineT                 ddrDout
);

    sramLineIf #(.IndexBits(IndexBits)) sramBus ();
    ddrLineIf                           ddrBus ();

    cacheCtrl #(.IndexBits(IndexBits)) i_ctrl (
        .clk      (clk),
        .rst      (rst),
        .hostAddr (hostAddr),
        .hostDin  (hostDin),
        .hostStb  (hostStb),
        .hostWe   (hostWe),
        .hostAck  (hostAck),
        .hostDout (hostDout),
        .sram     (sramBus.ctrl),
        .ddr      (ddrBus.ctrl)
    );

    sramPort #(.IndexBits(IndexBits)) i_sramPort (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (sramBus.port),
        .sramStb   (sramStb),
        .sramWe    (sramWe),
        .sramIndex (sramIndex),
        .sramDin   (sramDin),
        .sramAck   (sramAck),
        .sramDout  (sramDout)
    );

    ddrPort i_ddrPort (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (ddrBus.port),
        .ddrStb  (ddrStb),
        .ddrWe   (ddrWe),
        .ddrAddr (ddrAddr),
        .ddrDin  (ddrDin),
        .ddrAck  (ddrAck),
        .ddrDout (ddrDout)
    );

endmodule

//--- design/cacheCtrl.sv
`timescale 1ns/1ps

module cacheCtrl import l2GeomPkg::*, l2CtrlPkg::*; #(
    parameter int IndexBits = 16
) (
    input  logic    clk,
    input  logic    rst,
    input  addrT    hostAddr,
    input  lineT    hostDin,
    input  logic    hostStb,
    input  logic    hostWe,
    output logic    hostAck,
    output lineT    hostDout,
    sramLineIf.ctrl sram,
    ddrLineIf.ctrl  ddr
);

    ctrlStateT state;

    logic [IndexBits-1:0] clrIdx;
    logic                 hostAckD;

    // latched host request
    addrT reqAddr;
    lineT reqDin;
    logic reqWe;

    // progress through one request
    logic wbDone;
    logic fillDone;
    logic wrDone;

    logic [IndexBits-1:0] hostIdx;
    logic [IndexBits-1:0] reqIdx;
    tagT                  reqTag;
    tagT                  oldTag;
    logic                 hit;
    logic                 needWb;

    assign hostIdx = hostAddr[OffsetBits +: IndexBits];
    assign reqIdx  = reqAddr[OffsetBits +: IndexBits];
    assign reqTag  = reqAddr[TagLsb +: TagBits];
    assign oldTag  = sram.rLabel[LabelBits-1 -: TagBits];

    assign hit    = sram.rLabel[LabelValid] && oldTag == reqTag;
    assign needWb = sram.rLabel[LabelValid] && sram.rLabel[LabelDirty] && oldTag != reqTag;

    assign sram.wData = fillDone ? ddr.rData : reqDin;
    assign ddr.wData  = sram.rData;  // victim line from the lookup
    assign hostDout   = fillDone ? ddr.rData : sram.rData;

    // write-back goes to the old tag at the same index
    assign ddr.addr = ddr.write ?
        (addrT'(oldTag) << TagLsb) | (addrT'(reqIdx) << OffsetBits) :
        (addrT'(reqTag) << TagLsb) | (addrT'(reqIdx) << OffsetBits);

    // requests are issued from one-cycle states
    always_comb begin
        sram.req    = 1'b0;
        sram.write  = 1'b1;
        sram.index  = reqIdx;
        sram.wLabel = '0;
        ddr.req     = 1'b0;
        ddr.write   = 1'b0;
        hostAck     = 1'b0;
        case (state)
            Clear: begin
                sram.req   = 1'b1;
                sram.index = clrIdx;  // label stays invalid
            end
            Idle: begin
                sram.req   = hostStb && !hostAckD;
                sram.write = 1'b0;
                sram.index = hostIdx;
            end
            Decide: begin
                if (wrDone) begin
                    hostAck = 1'b1;
                end else if (fillDone) begin
                    sram.req    = 1'b1;
                    sram.wLabel = {reqTag, 2'b01};  // valid, clean
                end else if (needWb && !wbDone) begin
                    ddr.req   = 1'b1;
                    ddr.write = 1'b1;
                end else if (reqWe) begin
                    sram.req    = 1'b1;
                    sram.wLabel = {reqTag, 2'b11};  // valid, dirty
                end else if (hit) begin
                    hostAck = 1'b1;
                end else begin
                    ddr.req = 1'b1;  // fill
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= Clear;
            clrIdx   <= '0;
            hostAckD <= 1'b0;
            wbDone   <= 1'b0;
            fillDone <= 1'b0;
            wrDone   <= 1'b0;
        end else begin
            hostAckD <= hostAck;
            case (state)
                Clear: state <= ClearWait;
                ClearWait: begin
                    if (sram.done) begin
                        if (&clrIdx) begin
                            state <= Idle;
                        end else begin
                            clrIdx <= clrIdx + 1'b1;
                            state  <= Clear;
                        end
                    end
                end
                Idle: begin
                    if (sram.req) begin
                        reqAddr  <= hostAddr;
                        reqDin   <= hostDin;
                        reqWe    <= hostWe;
                        wbDone   <= 1'b0;
                        fillDone <= 1'b0;
                        wrDone   <= 1'b0;
                        state    <= LookupWait;
                    end
                end
                LookupWait: if (sram.done) state <= Decide;
                Decide: begin
                    if (hostAck) state <= Idle;
                    else if (sram.req) state <= WriteWait;
                    else if (ddr.write) state <= WbWait;
                    else state <= FillWait;
                end
                WbWait: begin
                    if (ddr.done) begin
                        wbDone <= 1'b1;
                        state  <= Decide;
                    end
                end
                FillWait: begin
                    if (ddr.done) begin
                        fillDone <= 1'b1;
                        state    <= Decide;
                    end
                end
                WriteWait: begin
                    if (sram.done) begin
                        wrDone <= 1'b1;
                        state  <= Decide;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

endmodule

//--- design/ddrPort.sv
`timescale 1ns/1ps

module ddrPort import l2GeomPkg::*; (
    input  logic  clk,
    input  logic  rst,
    ddrLineIf.port ctrl,
    output logic  ddrStb,
    output logic  ddrWe,
    output addrT  ddrAddr,
    output lineT  ddrDin,
    input  logic  ddrAck,
    input  lineT  ddrDout
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ddrStb    <= 1'b0;
            ctrl.done <= 1'b0;
        end else begin
            ddrStb    <= ctrl.req;
            ctrl.done <= ddrAck;  // done trails ack by a cycle
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.req) begin
            ddrWe   <= ctrl.write;
            ddrAddr <= ctrl.addr;
            ddrDin  <= ctrl.wData;
        end
    end

    // fill data is also latched on write-back acks
    always_ff @(posedge clk) begin
        if (ddrAck) begin
            ctrl.rData <= ddrDout;
        end
    end

endmodule

//--- design/sramPort.sv
`timescale 1ns/1ps

module sramPort import l2GeomPkg::*, l2CtrlPkg::*; #(
    parameter int IndexBits = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    sramLineIf.port              ctrl,
    output logic                 sramStb,
    output logic                 sramWe,
    output logic [IndexBits-1:0] sramIndex,
    output sramLineT             sramDin,
    input  logic                 sramAck,
    input  sramLineT             sramDout
);

    sramLineT packedLine;
    lineT     unpackedData;

    // payload sits in the low 32 bits of each stored word
    always_comb begin
        packedLine = '0;
        for (int w = 0; w < LineWords; w++) begin
            packedLine[w*SramWordWidth +: WordWidth] = ctrl.wData[w*WordWidth +: WordWidth];
        end
        packedLine[WordWidth +: LabelBits] = ctrl.wLabel;  // label above word 0
    end

    always_comb begin
        for (int w = 0; w < LineWords; w++) begin
            unpackedData[w*WordWidth +: WordWidth] = sramDout[w*SramWordWidth +: WordWidth];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sramStb   <= 1'b0;
            ctrl.done <= 1'b0;
        end else begin
            sramStb   <= ctrl.req;  // one-cycle strobe
            ctrl.done <= sramAck;
        end
    end

    // bus fields only change when a request is launched
    always_ff @(posedge clk) begin
        if (ctrl.req) begin
            sramWe    <= ctrl.write;
            sramIndex <= ctrl.index;
            sramDin   <= packedLine;
        end
    end

    always_ff @(posedge clk) begin
        if (sramAck) begin
            ctrl.rData  <= unpackedData;
            ctrl.rLabel <= sramDout[WordWidth +: LabelBits];
        end
    end

endmodule

//--- design/cacheIfs.sv
`timescale 1ns/1ps

interface sramLineIf import l2GeomPkg::*, l2CtrlPkg::*; #(
    parameter int IndexBits = 16
) ();
    logic                 req;
    logic                 write;
    logic [IndexBits-1:0] index;
    lineLabelT            wLabel;
    lineT                 wData;
    logic                 done;
    lineLabelT            rLabel;  // held from done until next req
    lineT                 rData;

    modport ctrl (output req, write, index, wLabel, wData, input done, rLabel, rData);
    modport port (input req, write, index, wLabel, wData, output done, rLabel, rData);
endinterface

interface ddrLineIf import l2GeomPkg::*; ();
    logic req;
    logic write;
    addrT addr;
    lineT wData;
    logic done;
    lineT rData;

    modport ctrl (output req, write, addr, wData, input done, rData);
    modport port (input req, write, addr, wData, output done, rData);
endinterface

//--- design/l2CtrlPkg.sv
package l2CtrlPkg;
    import l2GeomPkg::*;

    // tag in the top label bits, then dirty, then valid
    localparam int LabelBits  = TagBits + 2;
    localparam int LabelDirty = 1;
    localparam int LabelValid = 0;

    typedef logic [LabelBits-1:0] lineLabelT;

    typedef enum logic [2:0] {
        Clear,
        ClearWait,
        Idle,
        LookupWait,
        Decide,
        WbWait,
        FillWait,
        WriteWait
    } ctrlStateT;

endpackage

//--- design/l2GeomPkg.sv
package l2GeomPkg;

    localparam int AddrWidth     = 32;
    localparam int WordWidth     = 32;
    localparam int LineWords     = 16;
    localparam int OffsetBits    = 6;  // 64-byte lines
    localparam int TagLsb        = 22;
    localparam int TagBits       = AddrWidth - TagLsb;
    localparam int SramWordWidth = 48;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [TagBits-1:0]   tagT;

    // host and DDR view of a line
    typedef logic [LineWords*WordWidth-1:0] lineT;

    // stored view of 16 words of 48 bits
    typedef logic [LineWords*SramWordWidth-1:0] sramLineT;

endpackage
